// ==== src/vgen_config.svh ====
//######################################
// video generator configuration
// tiny text mode geometry, sync polarity
// and register reset values
//######################################
`ifndef VGEN_CONFIG_SVH
`define VGEN_CONFIG_SVH

// horizontal geometry in pixels, offscreen part leads each line
`define H_VISIBLE       64
`define H_FRONT         4
`define H_SYNC          8
`define H_BACK          12
`define H_OFFSCREEN     (`H_FRONT + `H_SYNC + `H_BACK)
`define H_TOTAL         (`H_OFFSCREEN + `H_VISIBLE)     // 88 clocks per line

// vertical geometry in lines, visible lines come first
`define V_VISIBLE       32
`define V_FRONT         2
`define V_SYNC          2
`define V_BACK          4
`define V_TOTAL         (`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK)

`define H_SYNC_POL      0                   // active level of hsync, 0 = negative sync
`define V_SYNC_POL      0                   // active level of vsync

`define FETCH_LEAD      3                   // cell fetch runs this many clocks ahead of pixels
`define CHARS_WIDE      (`H_VISIBLE / 8)    // default words per character row
`define REG_ADDR_W      3

`define RST_DISPSTART   0
`define RST_SCROLLY     0
`define RST_FONT_HEIGHT 15                  // 8x16 font by default
`define RST_FONT_BANK   0

`endif

// ==== src/vgen_pkg.sv ====
//######################################
// vgen_pkg
// scan state and register number types
// shared by the video generator blocks
//######################################
`include "vgen_config.svh"

package vgen_pkg;

    // scan phases, in counting order for both axes
    typedef enum logic [1:0] {
        PRE_SYNC  = 2'b00,
        SYNC      = 2'b01,
        POST_SYNC = 2'b10,
        VISIBLE   = 2'b11
    } scan_state_t;

    // config register numbers
    typedef enum logic [`REG_ADDR_W-1:0] {
        DISPSTART = 3'd0,     // text start word address
        LINEWIDTH = 3'd1,     // words per character row
        SCROLLY   = 3'd2,     // [3:0] starting font row
        FONTCTRL  = 3'd3      // [3:0] height-1, [9:8] bank
    } vgen_reg_t;

endpackage

// ==== src/video_timing.sv ====
//######################################
// video_timing
// horizontal and vertical scan FSMs
// making sync, display enable, the cell
// fetch window and line/frame events
//######################################
`timescale 1ns/10ps
`include "vgen_config.svh"

module video_timing (
    input  logic clk,
    input  logic reset_i,
    output logic hsync_o,        // raw active-high syncs
    output logic vsync_o,
    output logic active_o,       // visible area
    output logic fetch_o,        // cell fetch window
    output logic cell_start_o,   // one per 8 clocks in the window
    output logic line_end_o,     // last pixel of a line
    output logic frame_end_o     // last pixel of the frame
);
    import vgen_pkg::*;

    // last count of each horizontal state
    localparam logic [10:0] H_PRE_END   = 11'(`H_FRONT - 1);
    localparam logic [10:0] H_SYNC_END  = 11'(`H_FRONT + `H_SYNC - 1);
    localparam logic [10:0] H_POST_END  = 11'(`H_OFFSCREEN - 1);
    localparam logic [10:0] H_VIS_END   = 11'(`H_TOTAL - 1);
    // last line of each vertical state
    localparam logic [10:0] V_VIS_END   = 11'(`V_VISIBLE - 1);
    localparam logic [10:0] V_PRE_END   = 11'(`V_VISIBLE + `V_FRONT - 1);
    localparam logic [10:0] V_SYNC_END  = 11'(`V_VISIBLE + `V_FRONT + `V_SYNC - 1);
    localparam logic [10:0] V_POST_END  = 11'(`V_TOTAL - 1);
    // fetch window, leads the pixels by FETCH_LEAD
    localparam logic [10:0] H_FETCH_BEG = 11'(`H_OFFSCREEN - `FETCH_LEAD);
    localparam logic [10:0] H_FETCH_END = 11'(`H_TOTAL - `FETCH_LEAD);

    scan_state_t h_state;
    scan_state_t h_state_next;
    scan_state_t v_state;
    scan_state_t v_state_next;
    logic [10:0] h_count;
    logic [10:0] h_count_next;
    logic [10:0] h_limit;
    logic [10:0] v_count;
    logic [10:0] v_count_next;
    logic [10:0] v_limit;
    logic [2:0]  cell_phase;                        // pixel column inside the cell
    logic        line_last;
    logic        frame_last;

    always_comb begin
        case (h_state)
            PRE_SYNC:  h_limit = H_PRE_END;
            SYNC:      h_limit = H_SYNC_END;
            POST_SYNC: h_limit = H_POST_END;
            default:   h_limit = H_VIS_END;         // visible runs to line end
        endcase
        case (v_state)
            VISIBLE:   v_limit = V_VIS_END;
            PRE_SYNC:  v_limit = V_PRE_END;
            SYNC:      v_limit = V_SYNC_END;
            default:   v_limit = V_POST_END;        // back porch closes the frame
        endcase
    end

    always_comb line_last  = (h_state == VISIBLE) && (h_count == h_limit);
    always_comb frame_last = line_last && (v_state == POST_SYNC) && (v_count == v_limit);

    // states step when the count reaches the limit, wrapping VISIBLE -> PRE_SYNC
    always_comb h_state_next = (h_count == h_limit) ? scan_state_t'(h_state + 2'd1) : h_state;
    always_comb v_state_next = (line_last && v_count == v_limit) ?
                               scan_state_t'(v_state + 2'd1) : v_state;

    always_comb begin
        h_count_next = h_count + 11'd1;
        v_count_next = v_count;
        if (line_last) begin
            h_count_next = 11'd0;
            v_count_next = frame_last ? 11'd0 : v_count + 11'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state    <= PRE_SYNC;
            v_state    <= VISIBLE;                  // frame starts at the top visible line
            h_count    <= 11'd0;
            v_count    <= 11'd0;
            cell_phase <= 3'd0;
        end else begin
            h_state    <= h_state_next;
            v_state    <= v_state_next;
            h_count    <= h_count_next;
            v_count    <= v_count_next;
            cell_phase <= fetch_o ? cell_phase + 3'd1 : 3'd0;   // held at 0 outside the window
        end
    end

    always_comb hsync_o      = (h_state == SYNC);
    always_comb vsync_o      = (v_state == SYNC);
    always_comb active_o     = (h_state == VISIBLE) && (v_state == VISIBLE);
    always_comb fetch_o      = (v_state == VISIBLE) && (h_count >= H_FETCH_BEG) &&
                               (h_count < H_FETCH_END);
    always_comb cell_start_o = fetch_o && (cell_phase == 3'd0);
    always_comb line_end_o   = line_last;
    always_comb frame_end_o  = frame_last;

endmodule

// ==== src/text_fetch.sv ====
//######################################
// text_fetch
// config registers and character cell
// walker driving vram and font addresses
//######################################
`timescale 1ns/10ps
`include "vgen_config.svh"

module text_fetch (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                enable_i,       // sampled at frame end only
    input  logic                reg_wr_i,
    input  vgen_pkg::vgen_reg_t reg_num_i,
    input  logic [15:0]         reg_data_i,
    input  logic                fetch_i,
    input  logic                cell_start_i,
    input  logic                line_end_i,
    input  logic                frame_end_i,
    input  logic [15:0]         vram_data_i,    // {attr, char code}
    output logic                vram_sel_o,
    output logic [15:0]         vram_addr_o,
    output logic                font_sel_o,
    output logic [12:0]         font_addr_o,
    output logic                load_o,         // font byte valid for the shifter
    output logic [7:0]          attr_o,
    output logic                text_en_o
);
    import vgen_pkg::*;

    // config registers
    logic [15:0] text_start_addr;
    logic [15:0] text_line_width;
    logic [3:0]  fine_scrolly;
    logic [3:0]  font_height;                   // rows per cell minus one
    logic [1:0]  font_bank;

    // walker state
    logic [15:0] text_addr;                     // next cell word
    logic [15:0] text_line_addr;                // first word of current char row
    logic [15:0] next_row_addr;
    logic [3:0]  char_y;                        // font row within the cell
    logic        cell_go;

    always_comb next_row_addr = text_line_addr + text_line_width;
    always_comb cell_go       = fetch_i && cell_start_i;

    // font address comes straight off the vram bus, saves a cycle
    always_comb begin
        if (font_height[3]) begin
            font_addr_o = {font_bank[1], vram_data_i[7:0], char_y[3:0]};    // 8x16 cells
        end else begin
            font_addr_o = {font_bank, vram_data_i[7:0], char_y[2:0]};       // 8x8 cells
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            text_start_addr <= 16'(`RST_DISPSTART);
            text_line_width <= 16'(`CHARS_WIDE);
            fine_scrolly    <= 4'(`RST_SCROLLY);
            font_height     <= 4'(`RST_FONT_HEIGHT);
            font_bank       <= 2'(`RST_FONT_BANK);
        end else if (reg_wr_i) begin
            case (reg_num_i)
                DISPSTART: text_start_addr <= reg_data_i;
                LINEWIDTH: text_line_width <= reg_data_i;
                SCROLLY:   fine_scrolly    <= reg_data_i[3:0];
                FONTCTRL: begin
                    font_height <= reg_data_i[3:0];
                    font_bank   <= reg_data_i[9:8];
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            text_en_o      <= 1'b0;             // first frame stays blank
            vram_sel_o     <= 1'b0;
            font_sel_o     <= 1'b0;
            load_o         <= 1'b0;
            text_addr      <= 16'd0;
            text_line_addr <= 16'd0;
            char_y         <= 4'd0;
        end else begin
            vram_sel_o <= cell_go && text_en_o; // no vram traffic while disabled
            font_sel_o <= vram_sel_o;           // char code valid one clock later
            load_o     <= font_sel_o;           // font byte valid one clock later

            if (cell_go) begin
                text_addr <= text_addr + 16'd1;
            end

            if (line_end_i) begin
                // >= so a scroll past the font height still wraps
                if (char_y >= font_height) begin
                    char_y         <= 4'd0;
                    text_line_addr <= next_row_addr;
                    text_addr      <= next_row_addr;
                end else begin
                    char_y    <= char_y + 4'd1;
                    text_addr <= text_line_addr;    // repeat the row for the next font line
                end
            end

            if (frame_end_i) begin              // wins over line_end
                text_en_o      <= enable_i;
                char_y         <= fine_scrolly;
                text_addr      <= text_start_addr;
                text_line_addr <= text_start_addr;
            end
        end
    end

    // address and colour payload
    always_ff @(posedge clk) begin
        if (cell_go) begin
            vram_addr_o <= text_addr;
        end
        if (font_sel_o) begin
            attr_o <= vram_data_i[15:8];        // held until the shifter loads
        end
    end

endmodule

// ==== src/pixel_shifter.sv ====
//######################################
// pixel_shifter
// font line shifter, fore/back colour
// select and sync/de output alignment
//######################################
`timescale 1ns/10ps
`include "vgen_config.svh"

module pixel_shifter (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       load_i,
    input  logic [7:0] font_data_i,
    input  logic [7:0] attr_i,          // [7:4] back, [3:0] fore
    input  logic       text_en_i,
    input  logic       hsync_i,
    input  logic       vsync_i,
    input  logic       active_i,
    output logic [3:0] pal_index_o,
    output logic       hsync_o,
    output logic       vsync_o,
    output logic       de_o
);
    localparam logic H_POL = 1'(`H_SYNC_POL);
    localparam logic V_POL = 1'(`V_SYNC_POL);

    logic [7:0] shift_q;                // remaining font bits, msb next
    logic [7:0] attr_q;
    logic       pix_bit;
    logic [7:0] cur_attr;
    logic       show;

    // on a load the msb goes out this clock, so the bypass feeds it directly
    always_comb pix_bit  = load_i ? font_data_i[7] : shift_q[7];
    always_comb cur_attr = load_i ? attr_i : attr_q;
    always_comb show     = active_i && text_en_i;

    always_ff @(posedge clk) begin
        if (load_i) begin
            shift_q <= {font_data_i[6:0], 1'b0};    // byte minus the pixel sent now
            attr_q  <= attr_i;
        end else begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pal_index_o <= 4'd0;
            hsync_o     <= ~H_POL;
            vsync_o     <= ~V_POL;
            de_o        <= 1'b0;
        end else begin
            if (show) begin
                pal_index_o <= pix_bit ? cur_attr[3:0] : cur_attr[7:4];
            end else begin
                pal_index_o <= 4'd0;                // black outside the picture
            end
            hsync_o <= hsync_i ? H_POL : ~H_POL;
            vsync_o <= vsync_i ? V_POL : ~V_POL;
            de_o    <= show;
        end
    end

endmodule

// ==== src/video_gen.sv ====
//######################################
// video_gen
// text mode video generator top
//######################################
`timescale 1ns/10ps

module video_gen (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                enable_i,
    input  logic                reg_wr_i,
    input  vgen_pkg::vgen_reg_t reg_num_i,
    input  logic [15:0]         reg_data_i,
    output logic                vram_sel_o,
    output logic [15:0]         vram_addr_o,
    input  logic [15:0]         vram_data_i,
    output logic                font_sel_o,
    output logic [12:0]         font_addr_o,
    input  logic [7:0]          fontram_data_i,
    output logic [3:0]          pal_index_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                de_o
);
    // scan timing to fetch and pixel stages
    logic       fetch;
    logic       cell_start;
    logic       line_end;
    logic       frame_end;
    logic       hsync_raw;
    logic       vsync_raw;
    logic       active;
    // fetch to pixel stage
    logic       load;
    logic [7:0] attr;
    logic       text_en;

    video_timing u_timing (
        .clk         (clk),
        .reset_i     (reset_i),
        .hsync_o     (hsync_raw),
        .vsync_o     (vsync_raw),
        .active_o    (active),
        .fetch_o     (fetch),
        .cell_start_o(cell_start),
        .line_end_o  (line_end),
        .frame_end_o (frame_end)
    );

    text_fetch u_fetch (
        .clk         (clk),
        .reset_i     (reset_i),
        .enable_i    (enable_i),
        .reg_wr_i    (reg_wr_i),
        .reg_num_i   (reg_num_i),
        .reg_data_i  (reg_data_i),
        .fetch_i     (fetch),
        .cell_start_i(cell_start),
        .line_end_i  (line_end),
        .frame_end_i (frame_end),
        .vram_data_i (vram_data_i),
        .vram_sel_o  (vram_sel_o),
        .vram_addr_o (vram_addr_o),
        .font_sel_o  (font_sel_o),
        .font_addr_o (font_addr_o),
        .load_o      (load),
        .attr_o      (attr),
        .text_en_o   (text_en)
    );

    pixel_shifter u_pixel (
        .clk         (clk),
        .reset_i     (reset_i),
        .load_i      (load),
        .font_data_i (fontram_data_i),
        .attr_i      (attr),
        .text_en_i   (text_en),
        .hsync_i     (hsync_raw),
        .vsync_i     (vsync_raw),
        .active_i    (active),
        .pal_index_o (pal_index_o),
        .hsync_o     (hsync_o),
        .vsync_o     (vsync_o),
        .de_o        (de_o)
    );

endmodule

// ==== tests/video_gen_props.sv ====
//########################################
// video_gen_props
// sync width, blanking and memory select
// assertions bound to video_gen
//########################################
`timescale 1ns/10ps
`include "vgen_config.svh"

module video_gen_props (
    input logic clk,
    input logic reset_i,
    input logic hsync_i,
    input logic vsync_i,
    input logic de_i,
    input logic vram_sel_i,
    input logic font_sel_i
);
    logic       hs_act;
    logic       vs_act;
    logic [7:0] hs_len;                         // clocks of hsync so far

    assign hs_act = (hsync_i == 1'(`H_SYNC_POL));
    assign vs_act = (vsync_i == 1'(`V_SYNC_POL));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hs_len <= 8'd0;
        end else if (hs_act) begin
            hs_len <= hs_len + 8'd1;
        end else begin
            hs_len <= 8'd0;
        end
    end

    // at the first inactive clock the count holds the pulse width
    hsync_width: assert property (@(posedge clk) disable iff (reset_i)
        $fell(hs_act) |-> (hs_len == 8'(`H_SYNC)))
        else $error("hsync pulse lasted %0d clocks", hs_len);

    de_blanked: assert property (@(posedge clk) disable iff (reset_i)
        !(de_i && (hs_act || vs_act)))
        else $error("display enable high during sync");

    sel_exclusive: assert property (@(posedge clk) disable iff (reset_i)
        !(vram_sel_i && font_sel_i))
        else $error("vram and font selects in the same clock");

    font_after_vram: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_i |=> font_sel_i)
        else $error("font select missing after vram select");

    font_needs_vram: assert property (@(posedge clk) disable iff (reset_i)
        font_sel_i |-> $past(vram_sel_i))
        else $error("font select without a vram select before it");

endmodule

bind video_gen video_gen_props u_props (
    .clk       (clk),
    .reset_i   (reset_i),
    .hsync_i   (hsync_o),
    .vsync_i   (vsync_o),
    .de_i      (de_o),
    .vram_sel_i(vram_sel_o),
    .font_sel_i(font_sel_o)
);

// ==== tests/video_gen_tb.sv ====
//########################################
// video_gen_tb
// directed tests for the text mode video
// generator, with vram and font models
// and a pixel reference model
//########################################
`timescale 1ns/10ps
`include "vgen_config.svh"

module video_gen_tb;
    import vgen_pkg::*;

    localparam int   FRAME_CYCLES   = `H_TOTAL * `V_TOTAL;     // 3520 clocks
    localparam int   TIMEOUT_CYCLES = 14 * FRAME_CYCLES + 2000; // all tests plus margin
    localparam logic H_ACT  = 1'(`H_SYNC_POL);
    localparam logic H_IDLE = 1'(!`H_SYNC_POL);
    localparam logic V_ACT  = 1'(`V_SYNC_POL);

    logic        clk;
    logic        reset_i;
    logic        enable_i;
    logic        reg_wr_i;
    vgen_reg_t   reg_num_i;
    logic [15:0] reg_data_i;
    logic        vram_sel_o;
    logic [15:0] vram_addr_o;
    logic [15:0] vram_data = '0;
    logic        font_sel_o;
    logic [12:0] font_addr_o;
    logic [7:0]  font_data = '0;
    logic [3:0]  pal_index_o;
    logic        hsync_o;
    logic        vsync_o;
    logic        de_o;

    logic [15:0] vram_mem [256];
    logic [7:0]  font_mem [8192];
    logic [31:0] lfsr_state = 32'd80567;
    int          cycle_count = 0;
    string       test_name = "none";

    // expected configuration decoded from the register writes
    logic [15:0] cfg_start;
    logic [15:0] cfg_width;
    logic [3:0]  cfg_scroll;
    logic [3:0]  cfg_height;
    logic [1:0]  cfg_bank;

    video_gen u_video_gen (
        .clk           (clk),
        .reset_i       (reset_i),
        .enable_i      (enable_i),
        .reg_wr_i      (reg_wr_i),
        .reg_num_i     (reg_num_i),
        .reg_data_i    (reg_data_i),
        .vram_sel_o    (vram_sel_o),
        .vram_addr_o   (vram_addr_o),
        .vram_data_i   (vram_data),
        .font_sel_o    (font_sel_o),
        .font_addr_o   (font_addr_o),
        .fontram_data_i(font_data),
        .pal_index_o   (pal_index_o),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o),
        .de_o          (de_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                 // 40 ns period
    end

    // both memories answer one clock after the select
    always @(posedge clk) begin
        if (vram_sel_o) begin
            vram_data <= vram_mem[vram_addr_o[7:0]];   // 256 words so upper bits drop out
        end
        if (font_sel_o) begin
            font_data <= font_mem[font_addr_o];
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clocks", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_bits(input int n, output logic [15:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);         // one step per bit
            v = {v[14:0], lfsr_state[0]};
        end
    endtask

    task automatic fill_memories();
        int          i;
        logic [15:0] w;
        for (i = 0; i < 256; i++) begin
            random_bits(16, w);
            vram_mem[8'(i)] = w;
        end
        for (i = 0; i < 8192; i++) begin
            random_bits(8, w);
            font_mem[13'(i)] = w[7:0];
        end
    endtask

    // palette index of visible pixel (x, y) from the walk and font rules
    function automatic logic [3:0] expected_pixel(input int x, input int y);
        int          i;
        logic [15:0] line_addr;
        logic [15:0] cell_addr;
        logic [3:0]  row;
        logic [15:0] word;
        logic [12:0] faddr;
        logic [7:0]  fbyte;
        logic        bit_on;
        line_addr = cfg_start;
        row       = cfg_scroll;                 // first line starts at the fine scroll row
        for (i = 0; i < y; i++) begin
            if (row >= cfg_height) begin
                row       = 4'd0;
                line_addr = line_addr + cfg_width;  // next character row
            end else begin
                row = row + 4'd1;
            end
        end
        cell_addr = line_addr + 16'(x / 8);
        word      = vram_mem[cell_addr[7:0]];
        if (cfg_height[3]) begin
            faddr = {cfg_bank[1], word[7:0], row};      // 16 row cells
        end else begin
            faddr = {cfg_bank, word[7:0], row[2:0]};    // 8 row cells
        end
        fbyte  = font_mem[faddr];
        bit_on = fbyte[3'(7 - (x % 8))];                // msb is the leftmost pixel
        return bit_on ? word[11:8] : word[15:12];
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s %s expected %0d actual %0d", test_name, what, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic write_reg(input vgen_reg_t num, input logic [15:0] data);
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
        @(negedge clk);
        reg_wr_i = 1'b0;
        case (num)
            DISPSTART: cfg_start  = data;
            LINEWIDTH: cfg_width  = data;
            SCROLLY:   cfg_scroll = data[3:0];
            FONTCTRL: begin
                cfg_height = data[3:0];
                cfg_bank   = data[9:8];
            end
            default: begin
            end
        endcase
    endtask

    task automatic wait_vblank();
        while (vsync_o != V_ACT) @(negedge clk);
    endtask

    // compares every de_o pixel of the next frame with the model
    task automatic check_frame();
        int x;
        int y;
        wait_vblank();
        x = 0;
        y = 0;
        while (y < `V_VISIBLE) begin
            @(negedge clk);
            if (de_o) begin
                check_value($sformatf("pixel %0d,%0d", x, y), 32'(expected_pixel(x, y)),
                            32'(pal_index_o));
                x++;
                if (x == `H_VISIBLE) begin
                    x = 0;
                    y++;
                end
            end
        end
    endtask

    task automatic test_reset_idle();
        int n;
        test_name = "test_reset_idle";
        check_value("de_o", 0, 32'(de_o));
        check_value("vram_sel_o", 0, 32'(vram_sel_o));
        check_value("font_sel_o", 0, 32'(font_sel_o));
        check_value("pal_index_o", 0, 32'(pal_index_o));
        check_value("hsync_o", 32'(H_IDLE), 32'(hsync_o));
        check_value("vsync_o", 32'(!V_ACT), 32'(vsync_o));
        for (n = 0; n < FRAME_CYCLES; n++) begin     // text stays off until frame end
            @(negedge clk);
            check_value("de_o in first frame", 0, 32'(de_o));
            check_value("pal_index_o in first frame", 0, 32'(pal_index_o));
        end
    endtask

    task automatic test_sync_timing();
        int period;
        int width;
        int lines;
        int run;
        test_name = "test_sync_timing";
        while (hsync_o == H_ACT) @(negedge clk);
        while (hsync_o != H_ACT) @(negedge clk);    // first active clock
        period = 0;
        width  = 0;
        while (hsync_o == H_ACT) begin
            width++;
            period++;
            @(negedge clk);
        end
        while (hsync_o != H_ACT) begin
            period++;
            @(negedge clk);
        end
        check_value("hsync period", `H_TOTAL, period);
        check_value("hsync width", `H_SYNC, width);
        while (vsync_o == V_ACT) @(negedge clk);
        wait_vblank();
        width = 0;
        while (vsync_o == V_ACT) begin
            width++;
            @(negedge clk);
        end
        check_value("vsync width", `V_SYNC * `H_TOTAL, width);
        lines = 0;
        run   = 0;
        while (vsync_o != V_ACT) begin              // de runs up to the next vsync
            if (de_o) begin
                run++;
            end else if (run != 0) begin
                check_value("de run length", `H_VISIBLE, run);
                lines++;
                run = 0;
            end
            @(negedge clk);
        end
        check_value("visible lines", `V_VISIBLE, lines);
    endtask

    task automatic test_default_text();
        test_name = "test_default_text";
        check_frame();
    endtask

    task automatic test_registers();
        test_name = "test_registers";
        wait_vblank();                               // writes land before frame end
        write_reg(DISPSTART, 16'h0035);
        write_reg(LINEWIDTH, 16'd12);
        write_reg(FONTCTRL, 16'h010F);               // height 15, bank 1
        check_frame();
    endtask

    task automatic test_scroll_y();
        test_name = "test_scroll_y";
        wait_vblank();
        write_reg(SCROLLY, 16'd5);
        write_reg(FONTCTRL, 16'h0207);               // 8 row font in bank 2 wraps sooner
        check_frame();
    endtask

    task automatic test_disable();
        int n;
        int hs;
        test_name = "test_disable";
        wait_vblank();
        enable_i = 1'b0;                             // latched at the coming frame end
        while (vsync_o == V_ACT) @(negedge clk);
        n  = 0;
        hs = 0;
        while (vsync_o != V_ACT) begin
            check_value("de_o while disabled", 0, 32'(de_o));
            check_value("pal_index_o while disabled", 0, 32'(pal_index_o));
            if (hsync_o == H_ACT) begin
                hs++;
            end
            n++;
            @(negedge clk);
        end
        check_value("scan between vsyncs", (`V_TOTAL - `V_SYNC) * `H_TOTAL, n);
        check_value("hsync clocks", (`V_TOTAL - `V_SYNC) * `H_SYNC, hs);
    endtask

    initial begin
        reset_i    = 1'b1;
        enable_i   = 1'b1;
        reg_wr_i   = 1'b0;
        reg_num_i  = DISPSTART;
        reg_data_i = 16'd0;
        cfg_start  = 16'(`RST_DISPSTART);
        cfg_width  = 16'(`CHARS_WIDE);
        cfg_scroll = 4'(`RST_SCROLLY);
        cfg_height = 4'(`RST_FONT_HEIGHT);
        cfg_bank   = 2'(`RST_FONT_BANK);
        fill_memories();
        repeat (5) @(negedge clk);
        reset_i = 1'b0;
        test_reset_idle();
        test_sync_timing();
        test_default_text();
        test_registers();
        test_scroll_y();
        test_disable();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+src
src/vgen_pkg.sv
src/video_timing.sv
src/text_fetch.sv
src/pixel_shifter.sv
src/video_gen.sv
tests/video_gen_props.sv
tests/video_gen_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the video generator testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module video_gen_tb -o video_gen_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/video_gen_tb_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
